/* verilog/fetch_bus_pkg.sv */
////////////////////////////////////////
// Fetch bus is word wide and word aligned
////////////////////////////////////////

package fetch_bus_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    // Byte address on the program memory bus
    parameter int ADDR_W = 32;

    // One fetched word, also the decode instruction width
    parameter int WORD_W = 32;

    ////////////////////////////////////////
    // Address steps
    ////////////////////////////////////////

    // Distance between consecutive fetched words
    parameter int WORD_BYTES = 4;

    // Size of one compressed instruction
    parameter int HALF_BYTES = 2;

endpackage

/* verilog/rv_instr_pkg.sv */
////////////////////////////////////////
// RV32IC parcel view of a fetched word
////////////////////////////////////////

package rv_instr_pkg;

    ////////////////////////////////////////
    // Encoding
    ////////////////////////////////////////

    // One instruction parcel
    parameter int HALF_W = 16;

    // Low opcode bits of a full-length instruction
    // Any other value marks a compressed one
    parameter logic [1:0] OPCODE_QUAD_32 = 2'b11;

    ////////////////////////////////////////
    // Fetched word
    ////////////////////////////////////////

    // Upper and lower parcel of a word, lo at the lower address
    typedef struct packed {
        logic [HALF_W-1:0] hi;
        logic [HALF_W-1:0] lo;
    } half_pair_t;

    // Same word seen whole or as two parcels
    typedef union packed {
        logic [2*HALF_W-1:0] instr;
        half_pair_t          half;
    } fetch_word_t;

endpackage

/* verilog/fetch_request.sv */
////////////////////////////////////////
// One request outstanding at most; boot_addr must be stable in reset
// Redirected requests wait for a pending response to drain
////////////////////////////////////////

module fetch_request (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             fetch_enable,
    input  logic [fetch_bus_pkg::ADDR_W-1:0] boot_addr,
    input  logic [fetch_bus_pkg::ADDR_W-1:0] set_pc,
    input  logic                             set_pc_valid,
    input  logic                             almost_full,
    output logic                             instr_req,
    output logic [fetch_bus_pkg::ADDR_W-1:0] instr_addr,
    input  logic                             instr_gnt,
    input  logic                             instr_valid,
    input  logic                             instr_err,
    input  logic [fetch_bus_pkg::WORD_W-1:0] instr_rdata,
    output logic                             push,
    output logic [fetch_bus_pkg::WORD_W-1:0] push_word,
    output logic                             push_err
);

    localparam logic [1:0] ST_IDLE      = 2'd0;
    localparam logic [1:0] ST_WAIT_GNT  = 2'd1;
    localparam logic [1:0] ST_WAIT_DATA = 2'd2;
    localparam logic [1:0] ST_DISCARD   = 2'd3;

    logic [1:0]                      state;
    logic [fetch_bus_pkg::ADDR_W-1:0] prefetch_addr;
    logic [fetch_bus_pkg::ADDR_W-1:0] redirect_addr;
    logic [fetch_bus_pkg::ADDR_W-1:0] next_fetch_addr;
    logic                            can_issue;
    logic                            issue;

    // Bus addresses are always word aligned
    assign redirect_addr   = {set_pc[fetch_bus_pkg::ADDR_W-1:2], 2'b00};
    assign next_fetch_addr = set_pc_valid ? redirect_addr : prefetch_addr;

    // A redirect clears the FIFO, so room is guaranteed then
    assign can_issue = fetch_enable & (set_pc_valid | ~almost_full);

    // New request only when nothing is left in flight
    always_comb begin
        case (state)
            ST_IDLE:      issue = can_issue;
            ST_WAIT_DATA: issue = instr_valid & can_issue;
            ST_DISCARD:   issue = ~instr_req & instr_valid & can_issue;
            default:      issue = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // Request FSM
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= ST_IDLE;
            instr_req <= 1'b0;
        end else begin
            // Request drops on grant and rises on issue only
            if (issue) begin
                instr_req <= 1'b1;
            end else if (instr_gnt) begin
                instr_req <= 1'b0;
            end

            case (state)
                ST_IDLE: begin
                    if (issue) begin
                        state <= ST_WAIT_GNT;
                    end
                end
                ST_WAIT_GNT: begin
                    // Old address stays on the bus until granted
                    if (set_pc_valid) begin
                        state <= ST_DISCARD;
                    end else if (instr_gnt) begin
                        state <= ST_WAIT_DATA;
                    end
                end
                ST_WAIT_DATA, ST_DISCARD: begin
                    if (~instr_req && instr_valid) begin
                        state <= issue ? ST_WAIT_GNT : ST_IDLE;
                    end else if (set_pc_valid) begin
                        state <= ST_DISCARD;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            instr_addr <= next_fetch_addr;
        end
    end

    ////////////////////////////////////////
    // Prefetch address counter
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prefetch_addr <= {boot_addr[fetch_bus_pkg::ADDR_W-1:2], 2'b00};
        end else if (set_pc_valid) begin
            prefetch_addr <= redirect_addr;
        end else if (state == ST_WAIT_GNT && instr_gnt) begin
            prefetch_addr <= instr_addr + fetch_bus_pkg::ADDR_W'(fetch_bus_pkg::WORD_BYTES);
        end
    end

    // Responses in discard state or under a redirect are dropped
    assign push      = instr_valid & (state == ST_WAIT_DATA) & ~set_pc_valid;
    assign push_word = instr_rdata;
    assign push_err  = instr_err;

endmodule

/* verilog/prefetch_fifo.sv */
////////////////////////////////////////
// Push when full is ignored; almost_full at one free entry
////////////////////////////////////////

module prefetch_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             clear,
    input  logic                             push,
    input  logic [fetch_bus_pkg::WORD_W-1:0] push_word,
    input  logic                             push_err,
    input  logic                             pop,
    output rv_instr_pkg::fetch_word_t        head_word,
    output logic                             head_err,
    output logic                             empty,
    output logic                             almost_full
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    rv_instr_pkg::fetch_word_t word_mem [FIFO_DEPTH];
    logic                      err_mem  [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push & (count != CNT_W'(FIFO_DEPTH));
    assign do_pop  = pop & ~empty;

    ////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            word_mem[wr_ptr] <= rv_instr_pkg::fetch_word_t'(push_word);
            err_mem[wr_ptr]  <= push_err;
        end
    end

    assign head_word   = word_mem[rd_ptr];
    assign head_err    = err_mem[rd_ptr];
    assign empty       = (count == '0);
    assign almost_full = (count >= CNT_W'(FIFO_DEPTH - 1));

endmodule

/* verilog/instr_aligner.sv */
////////////////////////////////////////
// Compressed instructions leave zero-extended, not expanded
////////////////////////////////////////

module instr_aligner (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic [fetch_bus_pkg::ADDR_W-1:0] boot_addr,
    input  logic [fetch_bus_pkg::ADDR_W-1:0] set_pc,
    input  logic                             set_pc_valid,
    input  rv_instr_pkg::fetch_word_t        head_word,
    input  logic                             head_err,
    input  logic                             empty,
    output logic                             pop,
    input  logic                             ready_id,
    output logic [fetch_bus_pkg::ADDR_W-1:0] pc_id,
    output logic [fetch_bus_pkg::WORD_W-1:0] instr_id,
    output logic                             instr_valid_id,
    output logic                             compressed_id,
    output logic                             fetch_error_id
);

    localparam int EXT_W = fetch_bus_pkg::WORD_W - rv_instr_pkg::HALF_W;

    logic [fetch_bus_pkg::ADDR_W-1:0] pc;
    logic [fetch_bus_pkg::ADDR_W-1:0] pc_step;
    logic [fetch_bus_pkg::ADDR_W-1:0] pc_next;

    // Upper parcel of the last popped word, valid only at an odd halfword PC
    logic [rv_instr_pkg::HALF_W-1:0] hold_half;
    logic                            hold_valid;
    logic                            hold_err;

    logic                            head_lo_comp;
    logic                            hold_comp;
    logic                            load_out;
    logic                            advance;
    logic                            take_head;
    logic                            hold_drop;
    logic                            asm_valid;
    logic                            asm_comp;
    logic                            asm_err;
    logic [fetch_bus_pkg::WORD_W-1:0] asm_instr;

    assign head_lo_comp = (head_word.half.lo[1:0] != rv_instr_pkg::OPCODE_QUAD_32);
    assign hold_comp    = (hold_half[1:0] != rv_instr_pkg::OPCODE_QUAD_32);

    // Output register accepts a new instruction
    assign load_out = ready_id | ~instr_valid_id;
    assign advance  = load_out & ~set_pc_valid;

    ////////////////////////////////////////
    // Instruction assembly
    ////////////////////////////////////////

    always_comb begin
        asm_valid = 1'b0;
        asm_comp  = 1'b0;
        asm_err   = 1'b0;
        asm_instr = '0;
        take_head = 1'b0;
        hold_drop = 1'b0;
        pc_step   = '0;
        if (!pc[1]) begin
            // Word aligned, everything comes from the head
            if (!empty) begin
                take_head = 1'b1;
                asm_valid = 1'b1;
                asm_err   = head_err;
                if (head_lo_comp) begin
                    asm_instr = {{EXT_W{1'b0}}, head_word.half.lo};
                    asm_comp  = 1'b1;
                    pc_step   = fetch_bus_pkg::ADDR_W'(fetch_bus_pkg::HALF_BYTES);
                end else begin
                    asm_instr = head_word.instr;
                    pc_step   = fetch_bus_pkg::ADDR_W'(fetch_bus_pkg::WORD_BYTES);
                end
            end
        end else if (hold_valid) begin
            if (hold_comp) begin
                asm_valid = 1'b1;
                asm_comp  = 1'b1;
                asm_err   = hold_err;
                asm_instr = {{EXT_W{1'b0}}, hold_half};
                hold_drop = 1'b1;
                pc_step   = fetch_bus_pkg::ADDR_W'(fetch_bus_pkg::HALF_BYTES);
            end else if (!empty) begin
                // Straddling instruction, upper parcel from the next word
                take_head = 1'b1;
                asm_valid = 1'b1;
                asm_err   = hold_err | head_err;
                asm_instr = {head_word.half.lo, hold_half};
                pc_step   = fetch_bus_pkg::ADDR_W'(fetch_bus_pkg::WORD_BYTES);
            end
        end else if (!empty) begin
            // Odd redirect target, low parcel of this word is skipped
            take_head = 1'b1;
        end
    end

    assign pc_next = pc + pc_step;
    assign pop     = advance & take_head;

    ////////////////////////////////////////
    // PC and hold register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc         <= {boot_addr[fetch_bus_pkg::ADDR_W-1:1], 1'b0};
            hold_valid <= 1'b0;
        end else if (set_pc_valid) begin
            pc         <= {set_pc[fetch_bus_pkg::ADDR_W-1:1], 1'b0};
            hold_valid <= 1'b0;
        end else if (advance) begin
            pc <= pc_next;
            // Hold is needed exactly when the next PC is odd
            if (take_head || hold_drop) begin
                hold_valid <= pc_next[1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            hold_half <= head_word.half.hi;
            hold_err  <= head_err;
        end
    end

    ////////////////////////////////////////
    // Decode output register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instr_valid_id <= 1'b0;
        end else if (set_pc_valid) begin
            instr_valid_id <= 1'b0;
        end else if (load_out) begin
            instr_valid_id <= asm_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && asm_valid) begin
            pc_id          <= pc;
            instr_id       <= asm_instr;
            compressed_id  <= asm_comp;
            fetch_error_id <= asm_err;
        end
    end

endmodule

/* verilog/fetch_stage.sv */
////////////////////////////////////////
// FIFO_DEPTH of 2, 4, 8 or 16 words
////////////////////////////////////////

module fetch_stage #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic [fetch_bus_pkg::ADDR_W-1:0] boot_addr,
    input  logic                             fetch_enable,
    input  logic                             set_pc_valid,
    input  logic [fetch_bus_pkg::ADDR_W-1:0] set_pc,
    input  logic                             ready_id,
    output logic [fetch_bus_pkg::ADDR_W-1:0] pc_id,
    output logic [fetch_bus_pkg::WORD_W-1:0] instr_id,
    output logic                             instr_valid_id,
    output logic                             compressed_id,
    output logic                             fetch_error_id,
    output logic                             instr_req,
    output logic [fetch_bus_pkg::ADDR_W-1:0] instr_addr,
    input  logic                             instr_gnt,
    input  logic [fetch_bus_pkg::WORD_W-1:0] instr_rdata,
    input  logic                             instr_err,
    input  logic                             instr_valid
);

    // Request unit to FIFO
    logic                             push;
    logic [fetch_bus_pkg::WORD_W-1:0] push_word;
    logic                             push_err;
    logic                             almost_full;

    // FIFO to aligner
    rv_instr_pkg::fetch_word_t        head_word;
    logic                             head_err;
    logic                             empty;
    logic                             pop;

    fetch_request u_fetch_request (
        .clk          (clk),
        .reset_n      (reset_n),
        .fetch_enable (fetch_enable),
        .boot_addr    (boot_addr),
        .set_pc       (set_pc),
        .set_pc_valid (set_pc_valid),
        .almost_full  (almost_full),
        .instr_req    (instr_req),
        .instr_addr   (instr_addr),
        .instr_gnt    (instr_gnt),
        .instr_valid  (instr_valid),
        .instr_err    (instr_err),
        .instr_rdata  (instr_rdata),
        .push         (push),
        .push_word    (push_word),
        .push_err     (push_err)
    );

    // Redirect empties the buffer
    prefetch_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_prefetch_fifo (
        .clk         (clk),
        .reset_n     (reset_n),
        .clear       (set_pc_valid),
        .push        (push),
        .push_word   (push_word),
        .push_err    (push_err),
        .pop         (pop),
        .head_word   (head_word),
        .head_err    (head_err),
        .empty       (empty),
        .almost_full (almost_full)
    );

    instr_aligner u_instr_aligner (
        .clk            (clk),
        .reset_n        (reset_n),
        .boot_addr      (boot_addr),
        .set_pc         (set_pc),
        .set_pc_valid   (set_pc_valid),
        .head_word      (head_word),
        .head_err       (head_err),
        .empty          (empty),
        .pop            (pop),
        .ready_id       (ready_id),
        .pc_id          (pc_id),
        .instr_id       (instr_id),
        .instr_valid_id (instr_valid_id),
        .compressed_id  (compressed_id),
        .fetch_error_id (fetch_error_id)
    );

endmodule

/* testbench/tb_clock.sv */
////////////////////////////////////////
// 8 ns clock, reset_n low for the first 8 cycles
////////////////////////////////////////

module tb_clock (
    output logic clk,
    output logic reset_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        reset_n = 1'b0;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule

/* testbench/fetch_stage_assert.sv */
////////////////////////////////////////
// Bound into fetch_stage; memory bus and redirect output rules
////////////////////////////////////////

module fetch_stage_assert (
    input logic                             clk,
    input logic                             reset_n,
    input logic                             instr_req,
    input logic [fetch_bus_pkg::ADDR_W-1:0] instr_addr,
    input logic                             instr_gnt,
    input logic                             instr_valid,
    input logic                             set_pc_valid,
    input logic                             instr_valid_id
);

    timeunit 1ns;
    timeprecision 100ps;

    // Granted request still waiting for its response
    logic outstanding;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            outstanding <= 1'b0;
        end else if (instr_req && instr_gnt) begin
            outstanding <= 1'b1;
        end else if (instr_valid) begin
            outstanding <= 1'b0;
        end
    end

    req_stable: assert property (@(posedge clk) disable iff (!reset_n)
        instr_req && !instr_gnt |=> instr_req && $stable(instr_addr))
        else $error("instr_req or instr_addr changed before grant");

    addr_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        instr_req |-> instr_addr[1:0] == 2'b00)
        else $error("instr_addr is not word aligned");

    single_outstanding: assert property (@(posedge clk) disable iff (!reset_n)
        instr_req |-> !outstanding)
        else $error("new request raised while one is outstanding");

    redirect_drops_output: assert property (@(posedge clk) disable iff (!reset_n)
        set_pc_valid |=> !instr_valid_id)
        else $error("instr_valid_id high in the cycle after set_pc_valid");

endmodule

/* testbench/fetch_stage_tb.sv */
////////////////////////////////////////
// Program image is 1 KB and repeats above; upper address bits alter it
// Bus delays and ready_id come from one LFSR, seed 51
////////////////////////////////////////

module fetch_stage_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int                ADDR_W     = fetch_bus_pkg::ADDR_W;
    localparam int                WORD_W     = fetch_bus_pkg::WORD_W;
    localparam logic [ADDR_W-1:0] BOOT_ADDR  = 32'h0000_0040;
    localparam logic [ADDR_W-1:0] ERR_LO     = 32'h0000_0180;
    localparam logic [ADDR_W-1:0] ERR_HI     = 32'h0000_01A0;
    localparam logic [1:0]        QUAD_32    = 2'b11;
    localparam int                WAIT_LIMIT = 2000;

    logic              clk;
    logic              reset_n;
    logic              fetch_enable = 1'b1;
    logic              set_pc_valid = 1'b0;
    logic [ADDR_W-1:0] set_pc       = '0;
    logic              ready_id     = 1'b1;
    logic              instr_gnt    = 1'b0;
    logic              instr_valid  = 1'b0;
    logic              instr_err    = 1'b0;
    logic [WORD_W-1:0] instr_rdata  = '0;
    logic [ADDR_W-1:0] pc_id;
    logic [ADDR_W-1:0] instr_addr;
    logic [WORD_W-1:0] instr_id;
    logic              instr_valid_id;
    logic              compressed_id;
    logic              fetch_error_id;
    logic              instr_req;

    logic [31:0]       lfsr_state = 32'd51;
    logic [WORD_W-1:0] word_table [256];
    string             test_name = "reset";
    logic              ready_random = 1'b0;
    logic              timed_out = 1'b0;
    int                checks = 0;
    int                errors = 0;
    int                delivered = 0;
    int                err_deliveries = 0;
    int                start_errors;
    int                start_delivered;
    int                tests_run;

    tb_clock u_clock (.clk(clk), .reset_n(reset_n));

    fetch_stage #(.FIFO_DEPTH(4)) DUT (
        .clk(clk), .reset_n(reset_n), .boot_addr(BOOT_ADDR), .fetch_enable(fetch_enable),
        .set_pc_valid(set_pc_valid), .set_pc(set_pc), .ready_id(ready_id),
        .pc_id(pc_id), .instr_id(instr_id), .instr_valid_id(instr_valid_id),
        .compressed_id(compressed_id), .fetch_error_id(fetch_error_id),
        .instr_req(instr_req), .instr_addr(instr_addr), .instr_gnt(instr_gnt),
        .instr_rdata(instr_rdata), .instr_err(instr_err), .instr_valid(instr_valid)
    );

    bind fetch_stage fetch_stage_assert u_fetch_stage_assert (
        .clk(clk), .reset_n(reset_n), .instr_req(instr_req), .instr_addr(instr_addr),
        .instr_gnt(instr_gnt), .instr_valid(instr_valid), .set_pc_valid(set_pc_valid),
        .instr_valid_id(instr_valid_id)
    );

    ////////////////////////////////////////
    // Random source and program image
    ////////////////////////////////////////

    // Galois LFSR x^32+x^22+x^2+x+1, one step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [WORD_W-1:0] word_at(input logic [ADDR_W-1:0] addr);
        return word_table[addr[9:2]] ^ {addr[31:10], 10'b0};
    endfunction

    function automatic logic err_at(input logic [ADDR_W-1:0] addr);
        return (addr >= ERR_LO) && (addr < ERR_HI);
    endfunction

    function automatic logic [15:0] half_at(input logic [ADDR_W-1:0] addr);
        logic [WORD_W-1:0] w;
        w = word_at({addr[ADDR_W-1:2], 2'b00});
        return addr[1] ? w[31:16] : w[15:0];
    endfunction

    task automatic fill_table();
        logic [WORD_W-1:0] w;
        for (int i = 0; i < 256; i++) begin
            w = random_bits(32);
            // Push the mix toward full-length parcels
            if (random_bits(1) == 1) begin
                w[1:0] = QUAD_32;
            end
            if (random_bits(1) == 1) begin
                w[17:16] = QUAD_32;
            end
            word_table[i] = w;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    ////////////////////////////////////////
    // Memory model and ready_id
    ////////////////////////////////////////

    logic [ADDR_W-1:0] resp_addr;
    logic              resp_pending = 1'b0;
    logic              resp_busy = 1'b0;
    logic              gnt_armed = 1'b0;
    int                resp_wait;
    int                gnt_wait;

    always @(posedge clk) begin
        ready_id <= ready_random ? (random_bits(2) != 0) : 1'b1;
        if (!reset_n) begin
            instr_gnt    <= 1'b0;
            instr_valid  <= 1'b0;
            resp_pending = 1'b0;
            gnt_armed    = 1'b0;
        end else begin
            instr_valid <= 1'b0;
            // Request and grant on the same edge end the address phase
            if (instr_req && instr_gnt) begin
                instr_gnt    <= 1'b0;
                resp_addr    = instr_addr;
                resp_wait    = int'(random_bits(2));
                resp_pending = 1'b1;
                gnt_armed    = 1'b0;
            end else if (!resp_pending) begin
                if (!gnt_armed) begin
                    gnt_wait  = int'(random_bits(2));
                    gnt_armed = 1'b1;
                end
                // Zero wait means grant is already up when the request rises
                if (instr_req && gnt_wait != 0) begin
                    gnt_wait = gnt_wait - 1;
                end
                if (gnt_wait == 0) begin
                    instr_gnt <= 1'b1;
                end
            end
            if (resp_pending) begin
                if (resp_wait == 0) begin
                    instr_valid  <= 1'b1;
                    instr_rdata  <= word_at(resp_addr);
                    instr_err    <= err_at(resp_addr);
                    resp_pending = 1'b0;
                end else begin
                    resp_wait = resp_wait - 1;
                end
            end
            resp_busy <= resp_pending;
        end
    end

    ////////////////////////////////////////
    // Reference fetch model and output checks
    ////////////////////////////////////////

    logic [ADDR_W-1:0] model_pc;
    logic              holding = 1'b0;
    logic [ADDR_W-1:0] held_pc;
    logic [WORD_W-1:0] held_instr;
    logic              held_comp;
    logic              held_err;

    always @(posedge clk) begin
        logic [15:0]       lo;
        logic [WORD_W-1:0] exp_instr;
        logic [ADDR_W-1:0] next_pc;
        logic              exp_comp;
        logic              exp_err;
        if (!reset_n) begin
            model_pc = BOOT_ADDR;
            holding  = 1'b0;
        end else begin
            // Stalled output must not move
            if (holding) begin
                check_value({test_name, " hold valid"}, 32'd1, 32'(instr_valid_id));
                check_value({test_name, " hold pc"}, held_pc, pc_id);
                check_value({test_name, " hold instr"}, held_instr, instr_id);
                check_value({test_name, " hold compressed"}, 32'(held_comp), 32'(compressed_id));
                check_value({test_name, " hold error"}, 32'(held_err), 32'(fetch_error_id));
            end
            if (instr_valid_id && ready_id) begin
                lo       = half_at(model_pc);
                exp_comp = (lo[1:0] != QUAD_32);
                if (exp_comp) begin
                    exp_instr = {16'b0, lo};
                    exp_err   = err_at(model_pc);
                    next_pc   = model_pc + 32'd2;
                end else begin
                    exp_instr = {half_at(model_pc + 32'd2), lo};
                    exp_err   = err_at(model_pc) | err_at(model_pc + 32'd2);
                    next_pc   = model_pc + 32'd4;
                end
                check_value({test_name, " pc"}, model_pc, pc_id);
                check_value({test_name, " instr"}, exp_instr, instr_id);
                check_value({test_name, " compressed"}, 32'(exp_comp), 32'(compressed_id));
                check_value({test_name, " fetch error"}, 32'(exp_err), 32'(fetch_error_id));
                if (fetch_error_id) begin
                    err_deliveries <= err_deliveries + 1;
                end
                delivered <= delivered + 1;
                model_pc = next_pc;
            end
            if (set_pc_valid) begin
                model_pc = {set_pc[ADDR_W-1:1], 1'b0};
            end
            holding    = instr_valid_id && !ready_id && !set_pc_valid;
            held_pc    = pc_id;
            held_instr = instr_id;
            held_comp  = compressed_id;
            held_err   = fetch_error_id;
        end
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (!timed_out && !reset_n) begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("Timeout: reset_n never went high");
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_deliveries(input int count);
        int target;
        int cycles;
        target = delivered + count;
        cycles = 0;
        while (!timed_out && delivered < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("Timeout: %s got no %0d deliveries in %0d cycles",
                         test_name, count, WAIT_LIMIT);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_outstanding();
        int cycles;
        cycles = 0;
        while (!timed_out && !resp_busy) begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("Timeout: %s saw no outstanding response", test_name);
                timed_out = 1'b1;
            end
        end
    endtask

    // One-cycle pulse, driven from the current edge
    task automatic redirect_to(input logic [ADDR_W-1:0] addr);
        set_pc       <= addr;
        set_pc_valid <= 1'b1;
        @(posedge clk);
        set_pc_valid <= 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        start_errors    = errors;
        start_delivered = delivered;
        tests_run++;
    endtask

    task automatic end_test();
        $display("%s: %0d delivered, %0d errors%s", test_name, delivered - start_delivered,
                 errors - start_errors, timed_out ? ", stopped by timeout" : "");
    endtask

    initial begin
        logic [ADDR_W-1:0] target_pc;
        int                err_before;
        tests_run = 0;
        fill_table();
        wait_reset_release();

        start_test("sequential");
        wait_deliveries(100);
        end_test();

        start_test("backpressure");
        ready_random = 1'b1;
        wait_deliveries(100);
        end_test();

        start_test("redirect");
        for (int i = 0; i < 12; i++) begin
            target_pc = random_bits(9) << 1;
            // Every other redirect lands on a response in flight
            if (i % 2 == 1) begin
                wait_outstanding();
            end
            redirect_to(target_pc);
            wait_deliveries(8);
        end
        end_test();

        start_test("error_words");
        err_before = err_deliveries;
        redirect_to(32'h0000_017A);
        wait_deliveries(20);
        redirect_to(32'h0000_019E);
        wait_deliveries(10);
        check_value({test_name, " error seen"}, 32'd1, 32'(err_deliveries > err_before));
        end_test();

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* flist.f */
verilog/fetch_bus_pkg.sv
verilog/rv_instr_pkg.sv
verilog/fetch_request.sv
verilog/prefetch_fifo.sv
verilog/instr_aligner.sv
verilog/fetch_stage.sv
testbench/tb_clock.sv
testbench/fetch_stage_assert.sv
testbench/fetch_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the fetch stage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=fetch_stage_sim
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    --top-module fetch_stage_tb \
    --Mdir "$BUILD_DIR" -o "$SIM_BIN" \
    -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
